//--- Makefile
# Verilator build and run for the lfsr stepper testbench

VERILATOR ?= verilator
TOP       ?= tb_lfsr_stepper
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and power-on reset generator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period  = 20,  // ns, 40 ns period
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic por_n
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // released on a rising edge, like any other input
    initial begin
        por_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        por_n <= 1'b1;
    end

endmodule

//--- bench/tb_lfsr_stepper.sv
//////////////////////////////////////////////////////////////////////
// testbench for the lfsr stepper: cycle model, directed tests,
// compare tasks, timeout and summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lfsr_stepper
    import lfsr_pkg::*;
;

    localparam int max_cycles = 2000;  // tests need roughly 500 to 600

    logic        clk;
    logic        por_n;
    logic        test_rst_n;
    logic        rst_n;
    pin_in_t     ui_in;
    logic [7:0]  uo_out;
    logic [7:0]  uio_out;
    pin_out_t    dut_pins;

    // reference model registers
    logic        step_seen;
    logic        model_adv;
    lfsr_state_t model_state;
    logic        model_valid;
    pin_out_t    model_pins;
    tap_entry_t  model_taps;

    logic [31:0] rng_state = 32'h8003_9cab;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          failed_count = 0;
    int          errors_at_start;
    string       test_name;

    assign rst_n    = por_n & test_rst_n;
    assign dut_pins = {uio_out, uo_out};  // valid, value[14:8], value[7:0]

    tb_clock #(
        .half_period  (20),
        .reset_cycles (5)
    ) clock_inst (
        .clk   (clk),
        .por_n (por_n)
    );

    lfsr_stepper_top lfsr_stepper_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_out (uio_out)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic tap_entry_t tap_lookup(input lfsr_len_t len, input logic four);
        if (four) begin
            return taps4_table[len];
        end
        return taps2_table[len];
    endfunction

    // shift left, xor of masked state into bit 0, dead register on a bad mask
    function automatic lfsr_state_t model_next(input lfsr_state_t s, input tap_entry_t e);
        if (!e.valid) begin
            return '0;
        end
        return {s[state_w-2:0], ^(s & e.mask)};
    endfunction

    function automatic pin_out_t pins_of(input logic valid, input logic [out_value_w-1:0] value);
        pin_out_t p;
        p.valid = valid;
        p.value = value;
        return p;
    endfunction

    assign model_taps = tap_lookup(ui_in.length, ui_in.four_taps);

    always @(posedge clk) begin
        if (!rst_n) begin
            step_seen   <= 1'b0;
            model_adv   <= 1'b0;
            model_state <= lfsr_state_t'(1);
            model_valid <= 1'b1;
            model_pins  <= '0;
        end else begin
            step_seen <= ui_in.step;
            model_adv <= !ui_in.hold || (ui_in.step && !step_seen);  // strobe one cycle later
            if (model_adv) begin
                model_state <= model_next(model_state, model_taps);
                model_valid <= model_taps.valid;
            end
            model_pins <= pins_of(model_valid, model_state[out_value_w-1:0]);
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] rng_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            rng_state = rng_step(rng_state);
            bits = {bits[30:0], rng_state[0]};
        end
    endtask

    task automatic apply_inputs(input logic hold, input logic step, input logic four,
                                input lfsr_len_t len);
        pin_in_t p;
        p.hold      = hold;
        p.step      = step;
        p.four_taps = four;
        p.length    = len;
        @(posedge clk);
        ui_in <= p;
    endtask

    task automatic check_pins(input pin_out_t expected, input pin_out_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s: expected valid %0b value %h, actual valid %0b value %h",
                     test_name, expected.valid, expected.value, actual.valid, actual.value);
        end
    endtask

    task automatic check_valid(input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s: expected valid %0b, actual valid %0b",
                     test_name, expected, actual);
        end
    endtask

    // pins against the model on each falling edge
    task automatic run_checked(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_pins(model_pins, dut_pins);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic finish_test();
        if (error_count == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            failed_count++;
            $display("test %s: %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    // zero for the release cycle, then the seed with valid high
    task automatic check_reset_release();
        @(negedge clk);
        check_pins('0, dut_pins);
        @(negedge clk);
        check_pins(pins_of(1'b1, 15'd1), dut_pins);
    endtask

    // one step pulse, step high for high_cycles edges
    task automatic step_once(input int high_cycles);
        tap_entry_t  taps;
        lfsr_state_t expected;
        taps     = tap_lookup(ui_in.length, ui_in.four_taps);
        expected = model_next(model_state, taps);
        apply_inputs(1'b1, 1'b1, ui_in.four_taps, ui_in.length);
        run_checked(high_cycles);
        apply_inputs(1'b1, 1'b0, ui_in.four_taps, ui_in.length);
        run_checked(4);
        check_pins(pins_of(taps.valid, expected[out_value_w-1:0]), dut_pins);
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests

    task automatic test_reset();
        start_test("reset");
        @(posedge rst_n);
        check_reset_release();
        finish_test();
    endtask

    task automatic test_free_run_2();
        start_test("free_run_2taps");
        apply_inputs(1'b0, 1'b0, 1'b0, 5'd7);
        run_checked(142);  // full period of 127 plus pipeline
        finish_test();
    endtask

    task automatic test_free_run_4();
        logic [31:0] bits;
        lfsr_len_t   len;
        start_test("free_run_4taps");
        repeat (5) begin
            do begin
                draw_bits(len_w, bits);
                len = bits[len_w-1:0];
            end while (!taps4_table[len].valid);
            apply_inputs(1'b0, 1'b0, 1'b1, len);
            run_checked(40);
        end
        finish_test();
    endtask

    task automatic test_single_step();
        pin_out_t held;
        start_test("single_step");
        apply_inputs(1'b1, 1'b0, 1'b0, 5'd7);
        run_checked(4);  // let the last free-run strobe drain
        held = model_pins;
        repeat (8) begin
            @(negedge clk);
            check_pins(held, dut_pins);
        end
        repeat (3) step_once(1);
        step_once(20);  // long high still gives one advance
        finish_test();
    endtask

    task automatic test_invalid();
        start_test("invalid_setting");
        apply_inputs(1'b0, 1'b0, 1'b0, 5'd7);
        run_checked(4);
        apply_inputs(1'b0, 1'b0, 1'b0, 5'd8);  // no 2-tap mask at 8
        run_checked(3);
        check_pins('0, dut_pins);
        check_valid(1'b0, dut_pins.valid);
        apply_inputs(1'b0, 1'b0, 1'b0, 5'd7);
        run_checked(8);
        check_pins(pins_of(1'b1, 15'd0), dut_pins);  // stuck at zero
        @(posedge clk);
        test_rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        test_rst_n <= 1'b1;
        check_reset_release();
        finish_test();
    endtask

    initial begin
        ui_in      <= '{hold: 1'b1, step: 1'b0, four_taps: 1'b0, length: 5'd7};
        test_rst_n <= 1'b1;
        test_reset();
        test_free_run_2();
        test_free_run_4();
        test_single_step();
        test_invalid();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- common/lfsr_pkg.sv
//////////////////////////////////////////////////////////////////////
// lfsr package: widths, pin structs and the fibonacci tap tables
// for 2-tap and 4-tap feedback, indexed by register length
//////////////////////////////////////////////////////////////////////

package lfsr_pkg;

    localparam int state_w     = 32;
    localparam int len_w       = 5;
    localparam int out_value_w = 15;

    typedef logic [state_w-1:0] lfsr_state_t;
    typedef logic [len_w-1:0]   lfsr_len_t;

    // input pin map, msb first
    typedef struct packed {
        logic      hold;       // ui_in[7]
        logic      step;       // ui_in[6]
        logic      four_taps;  // ui_in[5]
        lfsr_len_t length;     // ui_in[4:0]
    } pin_in_t;

    // output word, split over uio_out and uo_out at the top
    typedef struct packed {
        logic                   valid;
        logic [out_value_w-1:0] value;
    } pin_out_t;

    //////////////////////////////////////////////////////////////////////
    // tap tables

    typedef struct packed {
        logic        valid;
        lfsr_state_t mask;
    } tap_entry_t;

    typedef tap_entry_t tap_table_t [32];

    // 2-tap masks, no 2-tap solution for 8, 12..14, 16, 19, 24, 26, 27, 30
    localparam tap_table_t taps2_table = '{
        '{1'b0, 32'h0000_0000},  // 0
        '{1'b0, 32'h0000_0000},  // 1
        '{1'b1, 32'h0000_0003},  // 2
        '{1'b1, 32'h0000_0006},  // 3
        '{1'b1, 32'h0000_000c},  // 4
        '{1'b1, 32'h0000_0014},  // 5
        '{1'b1, 32'h0000_0030},  // 6
        '{1'b1, 32'h0000_0060},  // 7
        '{1'b0, 32'h0000_0000},  // 8
        '{1'b1, 32'h0000_0110},  // 9
        '{1'b1, 32'h0000_0240},  // 10
        '{1'b1, 32'h0000_0500},  // 11
        '{1'b0, 32'h0000_0000},  // 12
        '{1'b0, 32'h0000_0000},  // 13
        '{1'b0, 32'h0000_0000},  // 14
        '{1'b1, 32'h0000_6000},  // 15
        '{1'b0, 32'h0000_0000},  // 16
        '{1'b1, 32'h0001_2000},  // 17
        '{1'b1, 32'h0002_0400},  // 18
        '{1'b0, 32'h0000_0000},  // 19
        '{1'b1, 32'h0009_0000},  // 20
        '{1'b1, 32'h0014_0000},  // 21
        '{1'b1, 32'h0030_0000},  // 22
        '{1'b1, 32'h0042_0000},  // 23
        '{1'b0, 32'h0000_0000},  // 24
        '{1'b1, 32'h0120_0000},  // 25
        '{1'b0, 32'h0000_0000},  // 26
        '{1'b0, 32'h0000_0000},  // 27
        '{1'b1, 32'h0900_0000},  // 28
        '{1'b1, 32'h1400_0000},  // 29
        '{1'b0, 32'h0000_0000},  // 30
        '{1'b1, 32'h4800_0000}   // 31
    };

    // 4-tap masks, valid from length 5 up
    localparam tap_table_t taps4_table = '{
        '{1'b0, 32'h0000_0000},  // 0
        '{1'b0, 32'h0000_0000},  // 1
        '{1'b0, 32'h0000_0000},  // 2
        '{1'b0, 32'h0000_0000},  // 3
        '{1'b0, 32'h0000_0000},  // 4
        '{1'b1, 32'h0000_001e},  // 5
        '{1'b1, 32'h0000_0036},  // 6
        '{1'b1, 32'h0000_0078},  // 7
        '{1'b1, 32'h0000_00b8},  // 8
        '{1'b1, 32'h0000_01b0},  // 9
        '{1'b1, 32'h0000_0360},  // 10
        '{1'b1, 32'h0000_0740},  // 11
        '{1'b1, 32'h0000_0ca0},  // 12
        '{1'b1, 32'h0000_1b00},  // 13
        '{1'b1, 32'h0000_3500},  // 14
        '{1'b1, 32'h0000_7400},  // 15
        '{1'b1, 32'h0000_b400},  // 16
        '{1'b1, 32'h0001_e000},  // 17
        '{1'b1, 32'h0003_9000},  // 18
        '{1'b1, 32'h0007_2000},  // 19
        '{1'b1, 32'h000c_a000},  // 20
        '{1'b1, 32'h001c_8000},  // 21
        '{1'b1, 32'h0027_0000},  // 22
        '{1'b1, 32'h006a_0000},  // 23
        '{1'b1, 32'h00d8_0000},  // 24
        '{1'b1, 32'h01e0_0000},  // 25
        '{1'b1, 32'h0388_0000},  // 26
        '{1'b1, 32'h0720_0000},  // 27
        '{1'b1, 32'h0ca0_0000},  // 28
        '{1'b1, 32'h1d00_0000},  // 29
        '{1'b1, 32'h3280_0000},  // 30
        '{1'b1, 32'h7800_0000}   // 31
    };

endpackage

//--- hdl/lfsr_pin_out.sv
//////////////////////////////////////////////////////////////////////
// output register: valid flag and low state bits onto the pins
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lfsr_pin_out
    import lfsr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  lfsr_state_t state,
    input  logic        valid,
    output pin_out_t    pins
);

    pin_out_t pins_next;

    always_comb begin
        pins_next.valid = valid;
        pins_next.value = state[out_value_w-1:0];  // upper bits not brought out
    end

    // loads every cycle, one cycle behind the core
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pins <= '0;
        end else begin
            pins <= pins_next;
        end
    end

endmodule

//--- hdl/lfsr_stepper_top.sv
//////////////////////////////////////////////////////////////////////
// lfsr stepper top: pin decode, step control, shift core and
// registered outputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lfsr_stepper_top
    import lfsr_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  pin_in_t    ui_in,
    output logic [7:0] uo_out,
    output logic [7:0] uio_out
);

    logic        advance;
    lfsr_state_t state;
    logic        valid;
    pin_out_t    pins;

    step_control step_control_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold    (ui_in.hold),
        .step    (ui_in.step),
        .advance (advance)
    );

    lfsr_shift_core lfsr_shift_core_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .length    (ui_in.length),
        .four_taps (ui_in.four_taps),
        .state     (state),
        .valid     (valid)
    );

    lfsr_pin_out lfsr_pin_out_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .valid (valid),
        .pins  (pins)
    );

    //////////////////////////////////////////////////////////////////////
    // pin split

    assign uio_out = {pins.valid, pins.value[out_value_w-1:8]};  // valid, value[14:8]
    assign uo_out  = pins.value[7:0];

endmodule

//--- hdl/step_control.sv
//////////////////////////////////////////////////////////////////////
// step control: free-run or one advance per rising edge of step
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module step_control (
    input  logic clk,
    input  logic rst_n,
    input  logic hold,
    input  logic step,
    output logic advance
);

    logic step_q;     // step as seen at the previous edge
    logic step_rise;

    assign step_rise = step && !step_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q <= 1'b0;
        end else begin
            step_q <= step;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // advance strobe

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            advance <= 1'b0;
        end else if (hold) begin
            advance <= step_rise;  // single pulse per step edge
        end else begin
            advance <= 1'b1;       // free run
        end
    end

    // held for three samples, so both strobes came from edge detects
    property p_single_pulse;
        @(posedge clk) disable iff (!rst_n)
        (hold && $past(hold) && $past(hold, 2)) |-> !(advance && $past(advance));
    endproperty

    a_single_pulse : assert property (p_single_pulse)
        else $error("advance high on two cycles in a row while held");

endmodule

//--- lfsr/lfsr_shift_core.sv
//////////////////////////////////////////////////////////////////////
// fibonacci shift register, seeded to 1, cleared on invalid taps
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lfsr_shift_core
    import lfsr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        advance,
    input  lfsr_len_t   length,
    input  logic        four_taps,
    output lfsr_state_t state,
    output logic        valid
);

    lfsr_state_t mask;
    logic        mask_valid;
    logic        feedback;

    lfsr_tap_table tap_table_inst (
        .length     (length),
        .four_taps  (four_taps),
        .mask       (mask),
        .mask_valid (mask_valid)
    );

    // xor of the tapped bits becomes the new lsb
    assign feedback = ^(state & mask);

    //////////////////////////////////////////////////////////////////////
    // state register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= lfsr_state_t'(1);  // nonzero seed
            valid <= 1'b1;
        end else if (advance) begin
            if (mask_valid) begin
                state <= {state[state_w-2:0], feedback};
                valid <= 1'b1;
            end else begin
                // zero state locks up until reset
                state <= '0;
                valid <= 1'b0;
            end
        end
    end

    // an advance on a bad setting leaves a dead register
    property p_invalid_clears;
        @(posedge clk) disable iff (!rst_n)
        (advance && !mask_valid) |=> (state == '0 && !valid);
    endproperty

    a_invalid_clears : assert property (p_invalid_clears)
        else $error("state not cleared after advance on invalid taps");

endmodule

//--- lfsr/lfsr_tap_table.sv
//////////////////////////////////////////////////////////////////////
// tap table lookup: feedback mask and its validity for the
// selected register length and tap count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lfsr_tap_table
    import lfsr_pkg::*;
(
    input  lfsr_len_t   length,
    input  logic        four_taps,
    output lfsr_state_t mask,
    output logic        mask_valid
);

    tap_entry_t entry_2;
    tap_entry_t entry_4;
    tap_entry_t entry_sel;

    // both tables indexed directly by length code
    assign entry_2 = taps2_table[length];
    assign entry_4 = taps4_table[length];

    always_comb begin
        if (four_taps) begin
            entry_sel = entry_4;
        end else begin
            entry_sel = entry_2;
        end
    end

    assign mask       = entry_sel.mask;
    assign mask_valid = entry_sel.valid;  // low for lengths without a solution

endmodule

//--- list.f
common/lfsr_pkg.sv
lfsr/lfsr_tap_table.sv
lfsr/lfsr_shift_core.sv
hdl/step_control.sv
hdl/lfsr_pin_out.sv
hdl/lfsr_stepper_top.sv
bench/tb_clock.sv
bench/tb_lfsr_stepper.sv
